/* design/img_filter_macros.svh */
// image filter build constants
// widths, line length, stage count, identification and register map

`ifndef IMG_FILTER_MACROS_SVH
`define IMG_FILTER_MACROS_SVH

// pixel stream
`define DATA_WIDTH          8
`define USER_WIDTH          4
`define MAX_X_NUM           64
`define POS_WIDTH           ($clog2(`MAX_X_NUM))
`define NUM_STAGES          2

// identification words
`define CORE_ID             32'h527a_0103
`define CORE_VERSION        32'h0001_0000

// register map, word addresses
`define ADR_CORE_ID         8'h00
`define ADR_CORE_VERSION    8'h01
`define ADR_CTL_CONTROL     8'h04
`define ADR_CTL_INDEX       8'h07
`define ADR_PARAM_ENABLE    8'h08
`define ADR_CURRENT_ENABLE  8'h18

`endif

/* design/img_filter_pkg.sv */
// image filter shared types
// pixel sideband, pixel beat, register request and update states

`include "img_filter_macros.svh"

package img_filter_pkg;

    // frame flags and user bits carried with every pixel
    typedef struct packed {
        logic                       line_first;
        logic                       line_last;
        logic                       pixel_first;
        logic                       pixel_last;
        logic                       de;
        logic [`USER_WIDTH-1:0]     user;
    } img_side_t;

    // one beat of the pixel stream
    typedef struct packed {
        logic                       valid;
        img_side_t                  side;
        logic [`DATA_WIDTH-1:0]     data;
    } img_pix_t;

    // register bus request, ack and read data go back separately
    typedef struct packed {
        logic                       stb;
        logic                       we;
        logic [7:0]                 addr;
        logic [31:0]                wdata;
    } reg_req_t;

    typedef enum logic {
        UPD_IDLE,
        UPD_ARMED
    } upd_state_t;

endpackage

/* design/img_gaussian_3x3.sv */
// configurable gaussian smoothing subsystem
// register block, frame-synchronous mask update and a cascade of stages

`include "img_filter_macros.svh"

module img_gaussian_3x3 import img_filter_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  reg_req_t    reg_i,
    output logic [31:0] reg_rdat_o,
    output logic        reg_ack_o,
    input  img_pix_t    s_img_i,
    output img_pix_t    m_img_o
);

    logic [2:0]                 ctl_control;
    logic [`NUM_STAGES-1:0]     param_enable;
    logic [`NUM_STAGES-1:0]     current_enable;
    logic                       applied;
    logic [7:0]                 upd_index;
    img_pix_t                   stage_img [`NUM_STAGES+1];

    img_reg_file u_reg_file (
        .clk              (clk),
        .reset            (reset),
        .reg_i            (reg_i),
        .applied_i        (applied),
        .current_enable_i (current_enable),
        .index_i          (upd_index),
        .reg_rdat_o       (reg_rdat_o),
        .reg_ack_o        (reg_ack_o),
        .ctl_control_o    (ctl_control),
        .param_enable_o   (param_enable)
    );

    img_param_update u_param_update (
        .clk              (clk),
        .reset            (reset),
        .s_img_i          (s_img_i),
        .ctl_control_i    (ctl_control),
        .param_enable_i   (param_enable),
        .applied_o        (applied),
        .current_enable_o (current_enable),
        .index_o          (upd_index)
    );

    // ------------------------------------------------------------------------
    // stage cascade
    // ------------------------------------------------------------------------
    assign stage_img[0] = s_img_i;

    for (genvar k = 0; k < `NUM_STAGES; k++) begin : g_stage
        img_gaussian_3x3_core u_core (
            .clk      (clk),
            .reset    (reset),
            .enable_i (current_enable[k]),
            .s_img_i  (stage_img[k]),
            .m_img_o  (stage_img[k+1])
        );
    end

    assign m_img_o = stage_img[`NUM_STAGES];

endmodule

/* design/img_gaussian_3x3_core.sv */
// one 3x3 gaussian smoothing stage, causal window with edge repeat
// two cycle latency, bypass passes the raw pixel with the same delay

`include "img_filter_macros.svh"

module img_gaussian_3x3_core import img_filter_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable_i,
    input  img_pix_t    s_img_i,
    output img_pix_t    m_img_o
);

    localparam int DW = `DATA_WIDTH;

    logic [`POS_WIDTH-1:0]  pos_x;
    logic [`POS_WIDTH-1:0]  pos_y;
    logic [DW-1:0]          up1;
    logic [DW-1:0]          up2;

    img_pos_counter u_pos_counter (
        .clk     (clk),
        .reset   (reset),
        .s_img_i (s_img_i),
        .x_o     (pos_x),
        .y_o     (pos_y)
    );

    img_line_buffer u_line_buffer (
        .clk     (clk),
        .we_i    (s_img_i.valid),
        .x_i     (pos_x),
        .data_i  (s_img_i.data),
        .up1_o   (up1),
        .up2_o   (up2)
    );

    // ------------------------------------------------------------------------
    // stage 1: align pixel with the rows above
    // ------------------------------------------------------------------------
    logic           s1_valid;
    logic           s1_en;
    img_side_t      s1_side;
    logic [DW-1:0]  s1_data;
    logic [1:0]     s1_xc;
    logic [1:0]     s1_yc;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= s_img_i.valid;
        end
    end

    // position clipped to 0, 1 or "2 and above"
    always_ff @(posedge clk) begin
        s1_en   <= enable_i;
        s1_side <= s_img_i.side;
        s1_data <= s_img_i.data;
        s1_xc   <= (pos_x < 2) ? pos_x[1:0] : 2'd2;
        s1_yc   <= (pos_y < 2) ? pos_y[1:0] : 2'd2;
    end

    // ------------------------------------------------------------------------
    // window, index 0 is row y-2, index 2 is row y
    // ------------------------------------------------------------------------
    logic [2:0][DW-1:0] col_cur;
    logic [2:0][DW-1:0] col_m1;
    logic [2:0][DW-1:0] col_m2;
    logic [2:0][DW-1:0] win_l;
    logic [2:0][DW-1:0] win_m;

    always_comb begin
        col_cur[2] = s1_data;
        col_cur[1] = (s1_yc == 2'd0) ? s1_data : up1;
        col_cur[0] = (s1_yc == 2'd0) ? s1_data : (s1_yc == 2'd1) ? up1 : up2;
        // left edge repeats the first real column
        win_m = (s1_xc == 2'd0) ? col_cur : col_m1;
        win_l = (s1_xc == 2'd0) ? col_cur : (s1_xc == 2'd1) ? col_m1 : col_m2;
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            col_m1 <= col_cur;
            col_m2 <= col_m1;
        end
    end

    // 1-2-1 along one column
    function automatic logic [DW+1:0] tap_sum(input logic [2:0][DW-1:0] c);
        return (DW+2)'(c[0]) + ((DW+2)'(c[1]) << 1) + (DW+2)'(c[2]);
    endfunction

    // weights add to 16, so the sum plus rounding fits DW+4 bits
    logic [DW+3:0] k_sum;

    assign k_sum = (DW+4)'(tap_sum(win_l)) + ((DW+4)'(tap_sum(win_m)) << 1)
                 + (DW+4)'(tap_sum(col_cur)) + (DW+4)'(8);

    // ------------------------------------------------------------------------
    // stage 2: output register
    // ------------------------------------------------------------------------
    logic           out_valid;
    img_side_t      out_side;
    logic [DW-1:0]  out_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_side <= s1_side;
        out_data <= s1_en ? k_sum[DW+3:4] : s1_data;
    end

    assign m_img_o = '{valid: out_valid, side: out_side, data: out_data};

endmodule

/* design/img_line_buffer.sv */
// two-row line memory
// returns the pixels one and two rows above the current column

`include "img_filter_macros.svh"

module img_line_buffer (
    input  logic                        clk,
    input  logic                        we_i,
    input  logic [`POS_WIDTH-1:0]       x_i,
    input  logic [`DATA_WIDTH-1:0]      data_i,
    output logic [`DATA_WIDTH-1:0]      up1_o,
    output logic [`DATA_WIDTH-1:0]      up2_o
);

    logic [`DATA_WIDTH-1:0] row1_mem [`MAX_X_NUM];
    logic [`DATA_WIDTH-1:0] row2_mem [`MAX_X_NUM];

    // registered reads see the contents before this write
    always_ff @(posedge clk) begin
        up1_o <= row1_mem[x_i];
        up2_o <= row2_mem[x_i];
    end

    // rows shift down by one at the written column
    always_ff @(posedge clk) begin
        if (we_i) begin
            row2_mem[x_i] <= row1_mem[x_i];
            row1_mem[x_i] <= data_i;
        end
    end

endmodule

/* design/img_param_update.sv */
// parameter update controller
// arms on a request and loads the active mask at the next frame start

`include "img_filter_macros.svh"

module img_param_update import img_filter_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  img_pix_t                    s_img_i,
    input  logic [2:0]                  ctl_control_i,
    input  logic [`NUM_STAGES-1:0]      param_enable_i,
    output logic                        applied_o,
    output logic [`NUM_STAGES-1:0]      current_enable_o,
    output logic [7:0]                  index_o
);

    upd_state_t state;
    logic       frame_start;

    assign frame_start = s_img_i.valid & s_img_i.side.line_first & s_img_i.side.pixel_first;
    assign applied_o   = (state == UPD_ARMED) & frame_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= UPD_IDLE;
            current_enable_o <= '0;
            index_o          <= '0;
        end else begin
            case (state)
                UPD_IDLE: begin
                    if (ctl_control_i[1]) begin
                        state <= UPD_ARMED;
                    end
                end
                UPD_ARMED: begin
                    if (applied_o) begin
                        // global enable off forces every stage to bypass
                        current_enable_o <= ctl_control_i[0] ? param_enable_i : '0;
                        index_o          <= index_o + 8'd1;
                        if (!ctl_control_i[2]) begin
                            state <= UPD_IDLE;
                        end
                    end else if (!ctl_control_i[1]) begin
                        // request withdrawn before a frame started
                        state <= UPD_IDLE;
                    end
                end
                default: state <= UPD_IDLE;
            endcase
        end
    end

endmodule

/* design/img_pos_counter.sv */
// pixel position tracker
// column and row of the current input pixel from the frame flags

`include "img_filter_macros.svh"

module img_pos_counter import img_filter_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  img_pix_t                    s_img_i,
    output logic [`POS_WIDTH-1:0]       x_o,
    output logic [`POS_WIDTH-1:0]       y_o
);

    logic [`POS_WIDTH-1:0] x_next;
    logic [`POS_WIDTH-1:0] y_cur;

    // row only moves on the first pixel of a line, and saturates
    always_comb begin
        x_o = s_img_i.side.pixel_first ? '0 : x_next;
        y_o = y_cur;
        if (s_img_i.side.pixel_first) begin
            if (s_img_i.side.line_first) begin
                y_o = '0;
            end else if (y_cur != '1) begin
                y_o = y_cur + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x_next <= '0;
            y_cur  <= '0;
        end else if (s_img_i.valid) begin
            x_next <= x_o + 1'b1;
            y_cur  <= y_o;
        end
    end

endmodule

/* design/img_reg_file.sv */
// register block for the smoothing subsystem
// identification, control word with auto-clear and requested enable mask

`include "img_filter_macros.svh"

module img_reg_file import img_filter_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  reg_req_t                    reg_i,
    input  logic                        applied_i,
    input  logic [`NUM_STAGES-1:0]      current_enable_i,
    input  logic [7:0]                  index_i,
    output logic [31:0]                 reg_rdat_o,
    output logic                        reg_ack_o,
    output logic [2:0]                  ctl_control_o,
    output logic [`NUM_STAGES-1:0]      param_enable_o
);

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_control_o  <= '0;
            param_enable_o <= '0;
        end else begin
            // request bit drops once the new mask is live
            if (applied_i && !ctl_control_o[2]) begin
                ctl_control_o[1] <= 1'b0;
            end
            // a bus write in the same cycle takes priority
            if (reg_i.stb && reg_i.we) begin
                case (reg_i.addr)
                    `ADR_CTL_CONTROL:  ctl_control_o  <= reg_i.wdata[2:0];
                    `ADR_PARAM_ENABLE: param_enable_o <= reg_i.wdata[`NUM_STAGES-1:0];
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    always_comb begin
        case (reg_i.addr)
            `ADR_CORE_ID:        reg_rdat_o = `CORE_ID;
            `ADR_CORE_VERSION:   reg_rdat_o = `CORE_VERSION;
            `ADR_CTL_CONTROL:    reg_rdat_o = 32'(ctl_control_o);
            `ADR_CTL_INDEX:      reg_rdat_o = 32'(index_i);
            `ADR_PARAM_ENABLE:   reg_rdat_o = 32'(param_enable_o);
            `ADR_CURRENT_ENABLE: reg_rdat_o = 32'(current_enable_i);
            default:             reg_rdat_o = '0;
        endcase
    end

    // single-cycle access
    assign reg_ack_o = reg_i.stb;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the smoothing testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -f src.f --top-module tb_img_gaussian_3x3
if ./obj_dir/Vtb_img_gaussian_3x3 | tee /dev/stderr | grep -qx "Test OK"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim/tb_img_gaussian_3x3.sv */
// testbench for the gaussian smoothing subsystem
// directed tests against a frame-level reference model

`include "img_filter_macros.svh"

module tb_img_gaussian_3x3 import img_filter_pkg::*; ();

    localparam int FW             = 8;
    localparam int FH             = 6;
    localparam int LATENCY        = 2 * `NUM_STAGES;
    // eight frames of 48 pixels with gaps, drains and register accesses
    localparam int TIMEOUT_CYCLES = 3000;

    logic           clk   = 1'b0;
    logic           reset = 1'b1;
    reg_req_t       reg_i = '0;
    logic [31:0]    reg_rdat;
    logic           reg_ack;
    img_pix_t       s_img = '0;
    img_pix_t       m_img;

    int             img_a [FH][FW];
    int             img_b [FH][FW];
    img_pix_t       exp_q [$];
    int             in_cyc_q [$];
    int             cycle = 0;
    img_pix_t       mon_exp;
    int             mon_in_cyc;

    img_gaussian_3x3 DUT (
        .clk        (clk),
        .reset      (reset),
        .reg_i      (reg_i),
        .reg_rdat_o (reg_rdat),
        .reg_ack_o  (reg_ack),
        .s_img_i    (s_img),
        .m_img_o    (m_img)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // ------------------------------------------------------------------------
    // output monitor, sampled away from the driving edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (s_img.valid) begin
                in_cyc_q.push_back(cycle);
            end
            if (m_img.valid) begin
                if (exp_q.size() == 0) begin
                    $display("output pixel at time %0t with no input pixel pending", $time);
                    $display("Test FAILED");
                    $fatal(1, "unexpected output");
                end else begin
                    mon_exp    = exp_q.pop_front();
                    mon_in_cyc = in_cyc_q.pop_front();
                    check("m_img_o.data", 32'(m_img.data), 32'(mon_exp.data));
                    check("m_img_o.side", 32'(m_img.side), 32'(mon_exp.side));
                    check("output latency", 32'(cycle - mon_in_cyc), 32'(LATENCY));
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // register bus
    // ------------------------------------------------------------------------
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_i <= '{stb: 1'b1, we: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        check("reg_ack_o", 32'(reg_ack), 32'd1);
        @(posedge clk);
        reg_i <= '0;
    endtask

    task automatic reg_read_check(input logic [7:0] addr, input logic [31:0] expected,
                                  input string name);
        @(posedge clk);
        reg_i <= '{stb: 1'b1, we: 1'b0, addr: addr, wdata: 32'd0};
        @(negedge clk);
        check("reg_ack_o", 32'(reg_ack), 32'd1);
        check(name, reg_rdat, expected);
        @(posedge clk);
        reg_i <= '0;
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    // 1-2-1 by 1-2-1 over rows y-2..y and columns x-2..x, edges repeated
    task automatic smooth_frame();
        int sum;
        int yy;
        int xx;
        for (int y = 0; y < FH; y++) begin
            for (int x = 0; x < FW; x++) begin
                sum = 8;
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        yy = (y - 2 + i < 0) ? 0 : y - 2 + i;
                        xx = (x - 2 + j < 0) ? 0 : x - 2 + j;
                        sum += (i == 1 ? 2 : 1) * (j == 1 ? 2 : 1) * img_a[yy][xx];
                    end
                end
                img_b[y][x] = sum >> 4;
            end
        end
        img_a = img_b;
    endtask

    function automatic img_pix_t make_beat(input int x, input int y,
                                           input logic [`USER_WIDTH-1:0] user,
                                           input logic [`DATA_WIDTH-1:0] data);
        img_pix_t b;
        b.valid            = 1'b1;
        b.side.line_first  = (y == 0);
        b.side.line_last   = (y == FH - 1);
        b.side.pixel_first = (x == 0);
        b.side.pixel_last  = (x == FW - 1);
        b.side.de          = 1'b1;
        b.side.user        = user;
        b.data             = data;
        return b;
    endfunction

    // random frame, expected result for the given active mask
    task automatic send_frame(input logic [`NUM_STAGES-1:0] mask, input int gap_max);
        logic [`DATA_WIDTH-1:0] src [FH][FW];
        logic [`USER_WIDTH-1:0] usr [FH][FW];
        img_pix_t               beat;
        int                     gap;
        for (int y = 0; y < FH; y++) begin
            for (int x = 0; x < FW; x++) begin
                src[y][x]   = `DATA_WIDTH'($urandom_range(0, 255));
                usr[y][x]   = `USER_WIDTH'($urandom_range(0, 15));
                img_a[y][x] = int'(src[y][x]);
            end
        end
        for (int k = 0; k < `NUM_STAGES; k++) begin
            if (mask[k]) begin
                smooth_frame();
            end
        end
        for (int y = 0; y < FH; y++) begin
            for (int x = 0; x < FW; x++) begin
                exp_q.push_back(make_beat(x, y, usr[y][x], `DATA_WIDTH'(img_a[y][x])));
            end
        end
        for (int y = 0; y < FH; y++) begin
            for (int x = 0; x < FW; x++) begin
                gap = int'($urandom_range(0, gap_max));
                repeat (gap) begin
                    @(posedge clk);
                    s_img <= '0;
                end
                @(posedge clk);
                s_img <= make_beat(x, y, usr[y][x], src[y][x]);
            end
        end
        @(posedge clk);
        s_img <= '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2 * LATENCY) @(posedge clk);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_reg_access();
        reg_read_check(`ADR_CORE_ID, `CORE_ID, "CORE_ID");
        reg_read_check(`ADR_CORE_VERSION, `CORE_VERSION, "CORE_VERSION");
        reg_read_check(8'h03, 32'd0, "unmapped register");
    endtask

    task automatic test_bypass();
        send_frame(2'b00, 0);
        wait_drain();
    endtask

    task automatic test_one_stage();
        reg_write(`ADR_PARAM_ENABLE, 32'd1);
        reg_write(`ADR_CTL_CONTROL, 32'd3);
        send_frame(2'b01, 0);
        wait_drain();
        reg_read_check(`ADR_CURRENT_ENABLE, 32'd1, "current enable");
        reg_read_check(`ADR_CTL_INDEX, 32'd1, "update index");
        reg_read_check(`ADR_CTL_CONTROL, 32'd1, "control word");
    endtask

    task automatic test_two_stages();
        reg_write(`ADR_PARAM_ENABLE, 32'd3);
        reg_write(`ADR_CTL_CONTROL, 32'd3);
        send_frame(2'b11, 3);
        wait_drain();
        reg_read_check(`ADR_CTL_INDEX, 32'd2, "update index");
    endtask

    task automatic test_update_rule();
        // request in the middle of a frame waits for the next frame start
        fork
            send_frame(2'b11, 0);
            begin
                repeat (20) @(posedge clk);
                reg_write(`ADR_PARAM_ENABLE, 32'd1);
                reg_write(`ADR_CTL_CONTROL, 32'd3);
                reg_read_check(`ADR_CURRENT_ENABLE, 32'd3, "current enable mid-frame");
            end
        join
        wait_drain();
        reg_read_check(`ADR_CURRENT_ENABLE, 32'd3, "current enable before frame");
        send_frame(2'b01, 0);
        wait_drain();
        reg_read_check(`ADR_CURRENT_ENABLE, 32'd1, "current enable");
        reg_read_check(`ADR_CTL_INDEX, 32'd3, "update index");
        reg_read_check(`ADR_CTL_CONTROL, 32'd1, "control word");
        // continuous mode
        reg_write(`ADR_PARAM_ENABLE, 32'd2);
        reg_write(`ADR_CTL_CONTROL, 32'd7);
        send_frame(2'b10, 0);
        wait_drain();
        reg_read_check(`ADR_CTL_INDEX, 32'd4, "update index");
        reg_read_check(`ADR_CTL_CONTROL, 32'd7, "control word");
        send_frame(2'b10, 0);
        wait_drain();
        reg_read_check(`ADR_CTL_INDEX, 32'd5, "update index");
        reg_read_check(`ADR_CTL_CONTROL, 32'd7, "control word");
        // global enable off
        reg_write(`ADR_CTL_CONTROL, 32'd2);
        send_frame(2'b00, 0);
        wait_drain();
        reg_read_check(`ADR_CURRENT_ENABLE, 32'd0, "current enable");
        reg_read_check(`ADR_CTL_INDEX, 32'd6, "update index");
        reg_read_check(`ADR_CTL_CONTROL, 32'd0, "control word");
    endtask

    initial begin
        void'($urandom(70487));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_reg_access();
        test_bypass();
        test_one_stage();
        test_two_stages();
        test_update_rule();
        $display("Test OK");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/img_filter_pkg.sv
design/img_reg_file.sv
design/img_param_update.sv
design/img_pos_counter.sv
design/img_line_buffer.sv
design/img_gaussian_3x3_core.sv
design/img_gaussian_3x3.sv
sim/tb_img_gaussian_3x3.sv
